/* Makefile */
# Verilator build and run for the e-link transmit path

VERILATOR ?= verilator
TOP       ?= tb_elink_top
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "STATUS: PASS" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* flist.f */
logic/elink_pkg.sv
logic/elink_tx_feeder.sv
logic/elink_enc8b10b.sv
logic/elink_rx_emulator.sv
logic/elink_top.sv
tb/elink_asserts.sv
tb/elink_checker.sv
tb/tb_elink_top.sv

/* logic/elink_enc8b10b.sv */
// E-link 8b10b lane encoder
// Requests a word every five clocks, sends K28.5 when none is waiting,
// encodes with running disparity and shifts out two bits per clock LSB first
`timescale 1ns/10ps
module elink_enc8b10b (
  input  logic                                getDataTrig,
  input  logic                                reset,
  output logic                                word_req,
  input  logic                                word_avail,
  input  elink_pkg::elink_word_t              word_in,
  output logic [elink_pkg::bits_per_clk-1:0]  edata
);

  logic [2:0]                    phase;    // Beat within symbol
  logic                          rd_pos;   // Running disparity, 0 is RD-
  logic [elink_pkg::sym_w-1:0]   shreg;    // Symbol leaving the lane
  logic [4:0]                    x;        // EDCBA
  logic [2:0]                    y;        // HGF
  logic                          is_k;
  logic                          alt7;
  logic [5:0]                    six;
  logic [3:0]                    four;
  logic                          rd_mid;   // Disparity between sub-blocks
  logic                          rd_next;
  logic [elink_pkg::sym_w-1:0]   sym_next; // Wire order

  assign word_req = phase == 3'd0; // Load slot
  assign edata    = shreg[elink_pkg::bits_per_clk-1:0];

  always_comb
  begin
    x    = 5'd28;
    y    = 3'd5; // K28.5 unless a word is waiting
    is_k = 1'b1;
    if (word_avail)
    begin
      case (word_in.kind)
        elink_pkg::kind_data:
        begin
          x    = word_in.data_byte[4:0];
          y    = word_in.data_byte[7:5];
          is_k = 1'b0;
        end
        elink_pkg::kind_sop: y = 3'd1;  // K28.1
        elink_pkg::kind_eop: y = 3'd6;  // K28.6
        default:             y = 3'd5;
      endcase
    end
    six    = elink_pkg::enc_5b6b(x, is_k, rd_pos);
    rd_mid = rd_pos ^ ($countones(six) != 3);
    // D.x.A7 where the primary code would extend a run
    alt7   = y == 3'd7 && !is_k &&
             ((!rd_mid && (x == 5'd17 || x == 5'd18 || x == 5'd20)) ||
              (rd_mid && (x == 5'd11 || x == 5'd13 || x == 5'd14)));
    four     = elink_pkg::enc_3b4b(y, rd_mid, alt7, is_k);
    rd_next  = rd_mid ^ ($countones(four) != 2);
    sym_next = elink_pkg::rev_sym({six, four});
  end

  always_ff @(posedge getDataTrig)
  begin
    if (reset)
    begin
      phase  <= 3'(elink_pkg::clks_per_sym - 1); // First request one cycle out
      rd_pos <= 1'b0;
      shreg  <= '0;
    end
    else
    begin
      phase <= (phase == 3'(elink_pkg::clks_per_sym - 1)) ? 3'd0 : phase + 3'd1;
      if (word_req)
      begin
        shreg  <= sym_next;
        rd_pos <= rd_next;
      end
      else
        shreg <= shreg >> elink_pkg::bits_per_clk; // Next beat down
    end
  end

endmodule

/* logic/elink_pkg.sv */
// E-link shared definitions
// Lane geometry, symbol kinds, word structs and the 8b10b sub-block tables
// Tables hold the RD- forms in abcdei / fghj order with a and f as MSB
package elink_pkg;

  localparam int num_lanes    = 4;  // E-link lanes
  localparam int lane_w       = 2;  // Lane index width
  localparam int sym_w        = 10; // 8b10b symbol
  localparam int bits_per_clk = 2;  // Beats are two bits wide
  localparam int clks_per_sym = 5;  // sym_w / bits_per_clk

  // K28.5 as sent, bit 0 leaves first
  localparam logic [sym_w-1:0] comma_neg = 10'b0101111100; // 001111 1010
  localparam logic [sym_w-1:0] comma_pos = 10'b1010000011; // 110000 0101

  typedef enum logic [1:0] {
    kind_data,  // D.x.y
    kind_sop,   // K28.1
    kind_eop,   // K28.6
    kind_idle   // K28.5 comma
  } elink_kind_e;

  typedef struct packed {
    elink_kind_e kind;
    logic [7:0]  data_byte; // HGFEDCBA
  } elink_word_t;

  typedef struct packed {
    elink_kind_e kind;
    logic [7:0]  data_byte;
    logic        code_err;  // Invalid sub-block or unknown K code
    logic        disp_err;  // Running disparity violated
  } elink_rx_t;

  // 5b/6b RD- codes for D.0 .. D.31
  localparam logic [5:0] tab_5b6b [32] = '{
    6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001, 6'b011001, 6'b111000,
    6'b111001, 6'b100101, 6'b010101, 6'b110100, 6'b001101, 6'b101100, 6'b011100, 6'b010111,
    6'b011011, 6'b100011, 6'b010011, 6'b110010, 6'b001011, 6'b101010, 6'b011010, 6'b111010,
    6'b110011, 6'b100110, 6'b010110, 6'b110110, 6'b001110, 6'b101110, 6'b011110, 6'b101011
  };

  // 3b/4b RD- codes, primary D.x.7
  localparam logic [3:0] tab_3b4b [8] = '{
    4'b1011, 4'b1001, 4'b0101, 4'b1100, 4'b1101, 4'b1010, 4'b0110, 4'b1110
  };

  function automatic logic [5:0] enc_5b6b(input logic [4:0] x, input logic is_k,
                                          input logic rd_pos);
    logic [5:0] c;
    c = is_k ? 6'b001111 : tab_5b6b[x]; // Only K.28 supported
    // Unbalanced codes and D.7 flip at positive disparity
    if (rd_pos && ($countones(c) != 3 || c == 6'b111000))
      c = ~c;
    return c;
  endfunction

  function automatic logic [3:0] enc_3b4b(input logic [2:0] y, input logic rd_pos,
                                          input logic alt7, input logic is_k);
    logic [3:0] c;
    c = (alt7 && y == 3'd7) ? 4'b0111 : tab_3b4b[y]; // A7 avoids a run of five
    if (rd_pos) begin
      if ($countones(c) != 2 || c == 4'b1100)
        c = ~c;
    end
    else if (is_k && $countones(c) == 2 && c != 4'b1100)
      c = ~c; // K28.y balanced codes invert at RD-
    return c;
  endfunction

  // Returns {ok, is_k, x}
  function automatic logic [6:0] dec_6b5b(input logic [5:0] c);
    logic [6:0] r;
    r = '0;
    for (int i = 0; i < 32; i++)
      if (c == enc_5b6b(5'(i), 1'b0, 1'b0) || c == enc_5b6b(5'(i), 1'b0, 1'b1))
        r = {2'b10, 5'(i)};
    if (c == 6'b001111 || c == 6'b110000)
      r = {2'b11, 5'd28};
    return r;
  endfunction

  // Returns {ok, y}; K codes need the disparity to tell y=1 from y=6
  function automatic logic [3:0] dec_4b3b(input logic [3:0] c, input logic is_k,
                                          input logic rd_pos);
    logic [3:0] r;
    r = '0;
    for (int i = 0; i < 8; i++)
      for (int j = 0; j < 4; j++)
        if ((!is_k || j[0] == rd_pos) && c == enc_3b4b(3'(i), j[0], j[1], is_k))
          r = {1'b1, 3'(i)};
    return r;
  endfunction

  // abcdei fghj (a at MSB) to wire order (a at bit 0), and back
  function automatic logic [sym_w-1:0] rev_sym(input logic [sym_w-1:0] s);
    logic [sym_w-1:0] r;
    for (int i = 0; i < sym_w; i++)
      r[i] = s[sym_w-1-i];
    return r;
  endfunction

endpackage

/* logic/elink_rx_emulator.sv */
// E-link receiver emulator
// Per lane comma alignment on a 12-bit beat history, 10-bit deserialization,
// 8b10b decode with code and disparity checks, non-idle symbols reported
`timescale 1ns/10ps
module elink_rx_emulator (
  input  logic                                getDataTrig,
  input  logic                                reset,
  input  logic [elink_pkg::bits_per_clk-1:0]  edata [elink_pkg::num_lanes],
  output logic [elink_pkg::num_lanes-1:0]     rx_valid,
  output logic [elink_pkg::num_lanes-1:0]     rx_locked,
  output elink_pkg::elink_rx_t                rx_sym [elink_pkg::num_lanes]
);

  for (genvar l = 0; l < elink_pkg::num_lanes; l++) begin : g_lane
    logic [elink_pkg::sym_w+elink_pkg::bits_per_clk-1:0] hist; // Newest beat on top
    logic [2:0]                  cnt;       // Free-running beat phase
    logic                        cand_vld;  // One comma seen
    logic                        cand_off;  // Bit offset of that comma
    logic [2:0]                  cand_ph;   // Beat phase of that comma
    logic                        locked;
    logic                        rd_pos;
    logic                        valid_q;
    elink_pkg::elink_rx_t        sym_q;
    logic [elink_pkg::sym_w-1:0] win0;      // Offset 0 window
    logic [elink_pkg::sym_w-1:0] win1;      // Offset 1 window
    logic                        hit0;
    logic                        hit1;
    logic                        hit_off;
    logic [elink_pkg::sym_w-1:0] hit_win;
    logic [elink_pkg::sym_w-1:0] code;      // abcdei fghj
    logic [6:0]                  d6;        // {ok, k, x}
    logic [3:0]                  d4;        // {ok, y}
    logic                        rd_mid;
    logic                        rd_next;
    logic                        code_err;
    logic                        disp_err;
    elink_pkg::elink_kind_e      kind;

    assign win0      = hist[11:2];
    assign win1      = hist[10:1];
    assign rx_locked[l] = locked;
    assign rx_valid[l]  = valid_q;
    assign rx_sym[l]    = sym_q;

    always_comb
    begin
      hit0    = win0 == elink_pkg::comma_neg || win0 == elink_pkg::comma_pos;
      hit1    = win1 == elink_pkg::comma_neg || win1 == elink_pkg::comma_pos;
      hit_off = !hit0; // Offset 0 wins a tie
      hit_win = hit0 ? win0 : win1;
      code    = elink_pkg::rev_sym(cand_off ? win1 : win0);
      d6      = elink_pkg::dec_6b5b(code[9:4]);
      // Unbalanced sub-block must oppose the current disparity
      disp_err = ($countones(code[9:4]) == 4 && rd_pos) ||
                 ($countones(code[9:4]) == 2 && !rd_pos);
      rd_mid   = rd_pos ^ ($countones(code[9:4]) != 3);
      d4       = elink_pkg::dec_4b3b(code[3:0], d6[5], rd_mid);
      disp_err = disp_err || ($countones(code[3:0]) == 3 && rd_mid) ||
                 ($countones(code[3:0]) == 1 && !rd_mid);
      rd_next  = rd_mid ^ ($countones(code[3:0]) != 2);
      code_err = !d6[6] || !d4[3];
      kind     = elink_pkg::kind_data;
      if (d6[5])
      begin
        case (d4[2:0])
          3'd1:    kind = elink_pkg::kind_sop;
          3'd6:    kind = elink_pkg::kind_eop;
          3'd5:    kind = elink_pkg::kind_idle;
          default: code_err = 1'b1; // K28.y not in use
        endcase
      end
    end

    always_ff @(posedge getDataTrig)
    begin
      hist <= {edata[l], hist[11:2]}; // First bit of a beat is its bit 0
    end

    always_ff @(posedge getDataTrig)
    begin
      if (reset)
      begin
        cnt      <= '0;
        cand_vld <= 1'b0;
        cand_off <= 1'b0;
        cand_ph  <= '0;
        locked   <= 1'b0;
        rd_pos   <= 1'b0;
        valid_q  <= 1'b0;
      end
      else
      begin
        cnt     <= (cnt == 3'(elink_pkg::clks_per_sym - 1)) ? 3'd0 : cnt + 3'd1;
        valid_q <= 1'b0;
        if (!locked)
        begin
          if (hit0 || hit1)
          begin
            if (cand_vld && cand_off == hit_off && cand_ph == cnt)
            begin
              locked <= 1'b1;
              rd_pos <= hit_win == elink_pkg::comma_neg; // RD- comma ends positive
            end
            else
            begin
              cand_vld <= 1'b1; // Restart on this comma
              cand_off <= hit_off;
              cand_ph  <= cnt;
            end
          end
          else if (cand_vld && cand_ph == cnt)
            cand_vld <= 1'b0; // Second comma missing
        end
        else if (cnt == cand_ph)
        begin
          rd_pos  <= rd_next;
          valid_q <= kind != elink_pkg::kind_idle || code_err || disp_err;
        end
      end
    end

    always_ff @(posedge getDataTrig)
    begin
      if (locked && cnt == cand_ph)
        sym_q <= {kind, d4[2:0], d6[4:0], code_err, disp_err};
    end
  end

endmodule

/* logic/elink_top.sv */
// E-link transmit path top
// Host feeder, four 8b10b lanes and the receiving link partner emulator
// Serial beats come out for observation
`timescale 1ns/10ps
module elink_top (
  input  logic                                getDataTrig,
  input  logic                                reset,
  input  logic                                host_valid,
  input  logic [elink_pkg::lane_w-1:0]        host_lane,
  input  elink_pkg::elink_word_t              host_word,
  output logic [elink_pkg::num_lanes-1:0]     lane_full,
  output logic [elink_pkg::num_lanes-1:0]     rx_valid,
  output logic [elink_pkg::num_lanes-1:0]     rx_locked,
  output elink_pkg::elink_rx_t                rx_sym [elink_pkg::num_lanes],
  output logic [elink_pkg::bits_per_clk-1:0]  edata [elink_pkg::num_lanes]
);

  logic [elink_pkg::num_lanes-1:0] word_req;   // Load slot per lane
  logic [elink_pkg::num_lanes-1:0] word_avail; // FIFO head valid
  elink_pkg::elink_word_t          word_out [elink_pkg::num_lanes];

  elink_tx_feeder u_feeder (
    .getDataTrig (getDataTrig),
    .reset       (reset),
    .host_valid  (host_valid),
    .host_lane   (host_lane),
    .host_word   (host_word),
    .word_req    (word_req),
    .word_avail  (word_avail),
    .word_out    (word_out),
    .lane_full   (lane_full)
  );

  for (genvar l = 0; l < elink_pkg::num_lanes; l++) begin : g_lane
    elink_enc8b10b u_enc (
      .getDataTrig (getDataTrig),
      .reset       (reset),
      .word_req    (word_req[l]),
      .word_avail  (word_avail[l]),
      .word_in     (word_out[l]),
      .edata       (edata[l])
    );
  end

  elink_rx_emulator u_rx (
    .getDataTrig (getDataTrig),
    .reset       (reset),
    .edata       (edata),
    .rx_valid    (rx_valid),
    .rx_locked   (rx_locked),
    .rx_sym      (rx_sym)
  );

endmodule

/* logic/elink_tx_feeder.sv */
// E-link transmit feeder
// Two-entry FIFO per lane, written from host strobes, read on lane requests
// Head of each FIFO is presented combinationally to its lane
`timescale 1ns/10ps
module elink_tx_feeder (
  input  logic                                getDataTrig,
  input  logic                                reset,
  input  logic                                host_valid,
  input  logic [elink_pkg::lane_w-1:0]        host_lane,
  input  elink_pkg::elink_word_t              host_word,
  input  logic [elink_pkg::num_lanes-1:0]     word_req,
  output logic [elink_pkg::num_lanes-1:0]     word_avail,
  output elink_pkg::elink_word_t              word_out [elink_pkg::num_lanes],
  output logic [elink_pkg::num_lanes-1:0]     lane_full
);

  for (genvar l = 0; l < elink_pkg::num_lanes; l++) begin : g_lane
    elink_pkg::elink_word_t mem [2]; // Payload only
    logic [1:0] wp;                  // Write pointer plus wrap bit
    logic [1:0] rp;                  // Read pointer plus wrap bit
    logic       push;
    logic       pop;

    // Idle is reserved for the lanes, full lanes drop the strobe
    assign push = host_valid && int'(host_lane) == l && !lane_full[l] &&
                  host_word.kind != elink_pkg::kind_idle;
    assign pop  = word_req[l] && word_avail[l]; // Lane consumes head this edge

    assign word_avail[l] = wp != rp;
    assign lane_full[l]  = (wp ^ rp) == 2'b10; // Same slot, other lap
    assign word_out[l]   = mem[rp[0]];

    always_ff @(posedge getDataTrig)
    begin
      if (reset)
      begin
        wp <= '0;
        rp <= '0;
      end
      else
      begin
        if (push)
          wp <= wp + 2'd1;
        if (pop)
          rp <= rp + 2'd1;
      end
    end

    always_ff @(posedge getDataTrig)
    begin
      if (push)
        mem[wp[0]] <= host_word;
    end
  end

endmodule

/* tb/elink_asserts.sv */
// Lane encoder assertions
// Load slot period, symbol weight and running disparity bookkeeping
`timescale 1ns/10ps
module elink_asserts (
  input  logic                          getDataTrig,
  input  logic                          reset,
  input  logic                          word_req,
  input  logic                          rd_pos,
  input  logic [elink_pkg::sym_w-1:0]   shreg
);

  logic [2:0] since_req; // Clocks since the last load slot
  logic       seen_req;

  always @(posedge getDataTrig)
  begin
    if (reset)
    begin
      since_req <= '0;
      seen_req  <= 1'b0;
    end
    else if (word_req)
    begin
      since_req <= '0;
      seen_req  <= 1'b1;
    end
    else
      since_req <= since_req + 3'd1;
  end

  // Exactly one request in five clocks
  a_req_period: assert property (@(posedge getDataTrig) disable iff (reset)
    seen_req |-> (word_req == (since_req == 3'd4)))
    else $error("word_req is not one cycle in five");

  // Loaded symbol holds four, five or six ones
  a_sym_weight: assert property (@(posedge getDataTrig) disable iff (reset)
    $past(word_req) |-> ($countones(shreg) >= 4 && $countones(shreg) <= 6))
    else $error("encoded symbol has a bad number of ones");

  // Disparity moves only between minus one and plus one
  a_rd_step: assert property (@(posedge getDataTrig) disable iff (reset)
    $past(word_req) |->
      ($countones(shreg) == 5 && rd_pos == $past(rd_pos)) ||
      ($countones(shreg) == 6 && !$past(rd_pos) && rd_pos) ||
      ($countones(shreg) == 4 && $past(rd_pos) && !rd_pos))
    else $error("running disparity left the range of plus or minus one");

endmodule

bind elink_enc8b10b elink_asserts u_asserts (
  .getDataTrig (getDataTrig),
  .reset       (reset),
  .word_req    (word_req),
  .rd_pos      (rd_pos),
  .shreg       (shreg)
);

/* tb/elink_checker.sv */
// E-link scoreboard
// Keeps a queue of sent words per lane and compares every reported symbol
// Watches the serial beats for runs longer than 8b10b allows
`timescale 1ns/10ps
module elink_checker (
  input  logic                                getDataTrig,
  input  logic                                reset,
  input  logic                                host_valid,
  input  logic [elink_pkg::lane_w-1:0]        host_lane,
  input  elink_pkg::elink_word_t              host_word,
  input  logic [elink_pkg::num_lanes-1:0]     rx_valid,
  input  logic [elink_pkg::num_lanes-1:0]     rx_locked,
  input  elink_pkg::elink_rx_t                rx_sym [elink_pkg::num_lanes],
  input  logic [elink_pkg::bits_per_clk-1:0]  edata [elink_pkg::num_lanes],
  input  logic                                end_run,
  output int                                  err_cnt,
  output int                                  mis_cnt,
  output int                                  pending
);

  elink_pkg::elink_word_t exp_q [elink_pkg::num_lanes][$]; // In send order
  logic                   done_rep;
  logic                   last_bit [elink_pkg::num_lanes];  // Latest wire bit
  int                     run_len [elink_pkg::num_lanes];   // Equal bits so far

  // Kind must match, byte only for data, no error flag on a clean link
  task automatic compare_symbol(input int ln, input elink_pkg::elink_rx_t got);
    elink_pkg::elink_word_t exp_w;
    if (exp_q[ln].size() == 0)
    begin
      $display("lane %0d reported a symbol that was never sent, at %0t", ln, $time);
      err_cnt++;
    end
    else
    begin
      exp_w = exp_q[ln].pop_front();
      if (got.kind != exp_w.kind || got.code_err || got.disp_err ||
          (exp_w.kind == elink_pkg::kind_data && got.data_byte != exp_w.data_byte))
      begin
        $display("mismatch at %0t: lane %0d expected %s %02h, got %s %02h code_err %0b disp_err %0b",
                 $time, ln, exp_w.kind.name(), exp_w.data_byte, got.kind.name(),
                 got.data_byte, got.code_err, got.disp_err);
        mis_cnt++;
      end
    end
  endtask

  // 8b10b never puts more than five equal bits in a row
  task automatic check_run(input int ln, input logic [elink_pkg::bits_per_clk-1:0] beat);
    for (int b = 0; b < elink_pkg::bits_per_clk; b++)
    begin
      if (run_len[ln] > 0 && beat[b] == last_bit[ln])
        run_len[ln]++;
      else
        run_len[ln] = 1;
      last_bit[ln] = beat[b]; // Bit 0 leaves first
      if (run_len[ln] == 6)
      begin
        $display("lane %0d sent six equal bits in a row, at %0t", ln, $time);
        err_cnt++;
      end
    end
  endtask

  always @(posedge getDataTrig)
  begin
    if (reset)
    begin
      for (int l = 0; l < elink_pkg::num_lanes; l++)
      begin
        exp_q[l].delete();
        run_len[l] = 0;
      end
      err_cnt  = 0;
      mis_cnt  = 0;
      pending  = 0;
      done_rep = 1'b0;
    end
    else
    begin
      if (host_valid && host_word.kind != elink_pkg::kind_idle)
        exp_q[host_lane].push_back(host_word); // Feeder stores it on this edge
      for (int l = 0; l < elink_pkg::num_lanes; l++)
        if (rx_valid[l])
          compare_symbol(l, rx_sym[l]);
      for (int l = 0; l < elink_pkg::num_lanes; l++)
        if (rx_locked[l])
          check_run(l, edata[l]); // Stream is steady once locked
        else
          run_len[l] = 0;
      if (end_run && !done_rep)
      begin
        for (int l = 0; l < elink_pkg::num_lanes; l++)
        begin
          if (exp_q[l].size() != 0)
          begin
            $display("lane %0d still owes %0d sent words at the end", l, exp_q[l].size());
            err_cnt++;
          end
          if (!rx_locked[l])
          begin
            $display("lane %0d never locked", l);
            err_cnt++;
          end
        end
        done_rep = 1'b1;
      end
      pending = 0;
      for (int l = 0; l < elink_pkg::num_lanes; l++)
        pending += exp_q[l].size();
    end
  end

endmodule

/* tb/elink_tests.txt */
// One host word per line as four hex digits LKBB
// L lane 0-3, K kind 0 data 1 K28.1 start 2 K28.6 end, BB data byte
0100
0011
00f1
00eb
0200
1055
20bc
10aa
2100
21f7
2200
3000
3001
30ff
307f
3002
12e7

/* tb/tb_elink_top.sv */
// E-link transmit path testbench
// Reads host words from the tests file and feeds them under lane_full
// The checker beside the DUT compares what the receiver emulator reports
`timescale 1ns/10ps
module tb_elink_top;

  localparam int max_tests = 64; // Room in the stimulus array
  localparam int lock_lim  = 8 * elink_pkg::clks_per_sym; // Start-up plus two commas

  logic                                getDataTrig = 1'b0;
  logic                                reset;
  logic                                host_valid;
  logic [elink_pkg::lane_w-1:0]        host_lane;
  elink_pkg::elink_word_t              host_word;
  logic [elink_pkg::num_lanes-1:0]     lane_full;
  logic [elink_pkg::num_lanes-1:0]     rx_valid;
  logic [elink_pkg::num_lanes-1:0]     rx_locked;
  elink_pkg::elink_rx_t                rx_sym [elink_pkg::num_lanes];
  logic [elink_pkg::bits_per_clk-1:0]  edata [elink_pkg::num_lanes];
  logic                                end_run;   // Asks the checker for its final checks
  int                                  err_cnt;
  int                                  mis_cnt;
  int                                  pending;   // Words sent but not yet received
  int                                  cycle_cnt = 0;
  int                                  timeout_lim = 1000000;
  logic [15:0]                         tests [max_tests]; // Lane, kind, byte
  int                                  n_tests;
  int                                  gap;
  int                                  lane;
  int                                  lock_wait; // Clocks spent waiting for lock

  elink_top u_elink_top (
    .getDataTrig (getDataTrig),
    .reset       (reset),
    .host_valid  (host_valid),
    .host_lane   (host_lane),
    .host_word   (host_word),
    .lane_full   (lane_full),
    .rx_valid    (rx_valid),
    .rx_locked   (rx_locked),
    .rx_sym      (rx_sym),
    .edata       (edata)
  );

  elink_checker u_checker (
    .getDataTrig (getDataTrig),
    .reset       (reset),
    .host_valid  (host_valid),
    .host_lane   (host_lane),
    .host_word   (host_word),
    .rx_valid    (rx_valid),
    .rx_locked   (rx_locked),
    .rx_sym      (rx_sym),
    .edata       (edata),
    .end_run     (end_run),
    .err_cnt     (err_cnt),
    .mis_cnt     (mis_cnt),
    .pending     (pending)
  );

  always #50 getDataTrig = ~getDataTrig; // 100 ns period

  // Run limit scales with the number of tests
  always @(posedge getDataTrig)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == timeout_lim)
    begin
      $display("timeout after %0d cycles, the tests did not finish", cycle_cnt);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  initial
  begin
    reset      = 1'b1;
    host_valid = 1'b0;
    host_lane  = '0;
    host_word  = '0;
    end_run    = 1'b0;
    void'($urandom(32'h59fc_2e0a));
    for (int i = 0; i < max_tests; i++)
      tests[i] = 16'hffff; // Lane digit f marks an unused entry
    $readmemh("tb/elink_tests.txt", tests);
    n_tests = 0;
    while (n_tests < max_tests && tests[n_tests] != 16'hffff)
      n_tests++;
    timeout_lim = n_tests * 5 * 4 + 200;

    repeat (2) @(posedge getDataTrig);
    reset <= 1'b0;

    // Idle commas must bring every lane into lock
    lock_wait = 0;
    @(negedge getDataTrig);
    while (rx_locked != '1 && lock_wait < lock_lim)
    begin
      lock_wait++;
      @(negedge getDataTrig);
    end

    // Words go out only over a locked link
    if (rx_locked == '1)
    begin
      for (int i = 0; i < n_tests; i++)
      begin
        gap  = $urandom_range(3, 0);
        lane = int'(tests[i][13:12]);
        @(negedge getDataTrig); // Lets the last push settle
        repeat (gap) @(negedge getDataTrig);
        while (lane_full[lane])
          @(negedge getDataTrig);
        @(posedge getDataTrig);
        host_valid <= 1'b1;
        host_lane  <= tests[i][13:12];
        host_word  <= '{kind: elink_pkg::elink_kind_e'(tests[i][9:8]),
                        data_byte: tests[i][7:0]};
        @(posedge getDataTrig);
        host_valid <= 1'b0;
      end

      // Drain, then the checker looks at leftovers and lock
      @(negedge getDataTrig);
      while (pending != 0)
        @(negedge getDataTrig);
    end
    @(posedge getDataTrig);
    end_run <= 1'b1;
    @(posedge getDataTrig);
    @(negedge getDataTrig);

    $display("tests %0d, errors %0d, mismatches %0d", n_tests, err_cnt, mis_cnt);
    if (err_cnt == 0 && mis_cnt == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule
